/* flist.f */
+incdir+verilog
+incdir+testbench
verilog/cmddec_field_pkg.sv
verilog/cmddec_ctrl_pkg.sv
verilog/regfile_strobe_dec.sv
verilog/cstore_cmd_dec.sv
verilog/level_cache_dec.sv
verilog/cmd_idb_decode.sv
testbench/tb_cmd_idb_decode.sv

/* testbench/tb_cmddec_tasks.svh */
////////////////////////////////////////////////////////////
// Testbench helpers for the command and IDB decode sheet
// Compare tasks per result kind, drive helpers, counters
////////////////////////////////////////////////////////////
`ifndef TB_CMDDEC_TASKS_SVH
`define TB_CMDDEC_TASKS_SVH

int err_cnt = 0;   // Failed checks
int chk_cnt = 0;   // All checks

// Register file strobe compare
task automatic check_rf(input string name,
                        input cmddec_ctrl_pkg::rf_strobe_t exp,
                        input cmddec_ctrl_pkg::rf_strobe_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("MISMATCH %s exp=%h act=%h at %0t", name, exp, act, $time);
  end
endtask

// Control-store strobe compare
task automatic check_cs(input string name,
                        input cmddec_ctrl_pkg::cs_strobe_t exp,
                        input cmddec_ctrl_pkg::cs_strobe_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("MISMATCH %s exp=%h act=%h at %0t", name, exp, act, $time);
  end
endtask

// Cache and level strobe compare
task automatic check_cache(input string name,
                           input cmddec_ctrl_pkg::cache_strobe_t exp,
                           input cmddec_ctrl_pkg::cache_strobe_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("MISMATCH %s exp=%h act=%h at %0t", name, exp, act, $time);
  end
endtask

// Single bit compare for the break line
task automatic check_bit(input string name, input logic exp, input logic act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("MISMATCH %s exp=%h act=%h at %0t", name, exp, act, $time);
  end
endtask

// Next drive point just after the rising edge
task automatic tick;
  @(posedge clk);
  #DRV_DLY;
endtask

// All inputs quiet with no command and no request
task automatic drive_idle;
  pd1      = 1'b0;
  ucode    = cmddec_field_pkg::UCODE_NOP;
  idb2     = 1'b0;
  lcs_n    = 1'b1;
  wrtrf    = 1'b0;
  pil      = 4'hF;   // Nonzero level
  mreq_n   = 1'b1;
  wca_n    = 1'b1;
  cgabrk_n = 1'b1;
endtask

`endif

/* testbench/tb_cmd_idb_decode.sv */
////////////////////////////////////////////////////////////
// Testbench for the command and IDB decode sheet
// Directed tests for reset, power down, register file and
// command decode, break gate, cache sequence, level zero
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cmddec_defs.svh"

module tb_cmd_idb_decode;

  localparam int CLK_PERIOD  = 100;
  localparam int DRV_DLY     = 10;    // Input skew after the edge
  localparam int TEST_CYCLES = 350;   // Sum over all tests rounded up

  logic clk;
  logic rst_n;
  logic pd1;
  cmddec_field_pkg::ucode_field_t ucode;
  logic idb2;
  logic lcs_n;
  logic wrtrf;
  cmddec_field_pkg::pil_t pil;
  logic mreq_n;
  logic wca_n;
  logic cgabrk_n;
  cmddec_ctrl_pkg::rf_strobe_t    rf;
  cmddec_ctrl_pkg::cs_strobe_t    cs;
  cmddec_ctrl_pkg::cache_strobe_t cache;
  wire logic brk_n;

  // Inactive output values
  localparam cmddec_ctrl_pkg::rf_strobe_t RF_IDLE = '{erf_n: 1'b1, rrf_n: 1'b1};
  localparam cmddec_ctrl_pkg::cs_strobe_t CS_IDLE = '{ldexm_n: 1'b1, vex: 1'b0,
                                                      opclcs: 1'b0, rwcs_n: 1'b1, rt_n: 1'b1};
  localparam cmddec_ctrl_pkg::cache_strobe_t CACHE_IDLE_V = '{cup: 1'b0, cwr: 1'b0, lev0: 1'b0};

  `include "tb_cmddec_tasks.svh"

  cmd_idb_decode u_cmd_idb_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .pd1      (pd1),
    .ucode    (ucode),
    .idb2     (idb2),
    .lcs_n    (lcs_n),
    .wrtrf    (wrtrf),
    .pil      (pil),
    .mreq_n   (mreq_n),
    .wca_n    (wca_n),
    .cgabrk_n (cgabrk_n),
    .rf       (rf),
    .cs       (cs),
    .cache    (cache),
    .brk_n    (brk_n)
  );

  // Register file rules
  function automatic cmddec_ctrl_pkg::rf_strobe_t exp_rf(input cmddec_field_pkg::csidbs_t idbs,
                                                         input logic wr, input logic lcs);
    cmddec_ctrl_pkg::rf_strobe_t e;
    e.rrf_n = !((idbs == `IDBS_RF) && lcs);
    e.erf_n = !(wr && lcs);
    return e;
  endfunction

  // Control-store rules
  function automatic cmddec_ctrl_pkg::cs_strobe_t exp_cs(
      input cmddec_field_pkg::ucode_field_t u, input logic lcs, input logic i2);
    cmddec_ctrl_pkg::cs_strobe_t e;
    e.ldexm_n = (u.cscomm != `CMD_LDEXM);
    e.vex     = (u.cscomm == `CMD_VEX) && (u.csmis == `MIS_VEX);
    e.opclcs  = !lcs && i2;
    e.rwcs_n  = (u.cscomm != `CMD_RWCS);
    e.rt_n    = (u.cscomm != `CMD_RET);
    return e;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog sized from the test length
  initial begin
    #((TEST_CYCLES + 50) * CLK_PERIOD);
    $display("Timeout: the tests did not complete in the allowed time");
    $display("Finished with errors");
    $finish;
  end

  // Reset values then pd1 forcing everything inactive
  task automatic test_reset_pd;
    cmddec_ctrl_pkg::cache_strobe_t e_c;
    check_rf("rf", RF_IDLE, rf);
    check_cs("cs", CS_IDLE, cs);
    check_cache("cache", CACHE_IDLE_V, cache);
    check_bit("brk_n", 1'b1, brk_n);
    pd1    = 1'b1;
    ucode  = '{cscomm: `CMD_VEX, csidbs: `IDBS_RF, csmis: `MIS_VEX};
    wrtrf  = 1'b1;
    idb2   = 1'b1;
    pil    = '0;
    mreq_n = 1'b0;
    wca_n  = 1'b0;
    repeat (3) begin
      tick();
      check_rf("rf", RF_IDLE, rf);
      check_cs("cs", CS_IDLE, cs);
      check_cache("cache", CACHE_IDLE_V, cache);
      check_bit("brk_n", 1'b1, brk_n);
    end
    pd1 = 1'b0;   // Same inputs now decode
    tick();
    check_rf("rf", '{erf_n: 1'b0, rrf_n: 1'b0}, rf);
    check_cs("cs", exp_cs(ucode, 1'b1, 1'b1), cs);
    e_c = '{cup: 1'b0, cwr: 1'b1, lev0: 1'b1};
    check_cache("cache", e_c, cache);
    pd1 = 1'b1;   // Abort mid access
    tick();
    check_rf("rf", RF_IDLE, rf);
    check_cs("cs", CS_IDLE, cs);
    check_cache("cache", CACHE_IDLE_V, cache);
    drive_idle();
    tick();
    check_cache("cache", CACHE_IDLE_V, cache);   // No leftover cup
  endtask

  // All IDB sources against wrtrf and lcs_n
  task automatic test_rf;
    cmddec_ctrl_pkg::rf_strobe_t e;
    for (int s = 0; s < 32; s++) begin
      for (int c = 0; c < 4; c++) begin
        ucode.csidbs = s[4:0];
        wrtrf        = c[0];
        lcs_n        = c[1];
        e            = exp_rf(s[4:0], c[0], c[1]);
        tick();
        check_rf("rf", e, rf);
      end
    end
    drive_idle();
  endtask

  // Every command and misc back to back
  task automatic test_cmd;
    cmddec_ctrl_pkg::cs_strobe_t e;
    for (int k = 0; k < 128; k++) begin
      ucode.cscomm = k[6:2];
      ucode.csmis  = k[1:0];
      idb2         = $urandom_range(1);
      lcs_n        = $urandom_range(1);
      e            = exp_cs(ucode, lcs_n, idb2);
      tick();
      check_cs("cs", e, cs);
    end
    drive_idle();
  endtask

  // Break line follows cgabrk_n and the registered vex
  // A qualified vex every fourth cycle meets both cgabrk_n levels
  task automatic test_brk;
    cmddec_ctrl_pkg::cs_strobe_t e;
    for (int i = 0; i < 16; i++) begin
      ucode.cscomm = (i % 2 == 1) ? `CMD_VEX : 5'($urandom);
      ucode.csmis  = (i % 4 == 1) ? `MIS_VEX : 2'($urandom);
      cgabrk_n     = i[2];
      #1;
      check_bit("brk_n", cgabrk_n | cs.vex, brk_n);
      e = exp_cs(ucode, lcs_n, idb2);
      tick();
      check_cs("cs", e, cs);
    end
    drive_idle();
  endtask

  // Single, ignored, partial and held write requests
  task automatic test_cache;
    logic [15:0] mreq_pat;
    logic [15:0] wca_pat;
    logic        req;
    int          phase;   // 0 idle, 1 write, 2 update
    cmddec_ctrl_pkg::cache_strobe_t e;
    mreq_pat = 16'b0010_0111_1111_1101;   // Bit 0 first and 1 means low
    wca_pat  = 16'b0100_0111_1111_0001;
    phase    = 0;
    for (int i = 0; i < 16; i++) begin
      mreq_n = !mreq_pat[i];
      wca_n  = !wca_pat[i];
      req    = mreq_pat[i] && wca_pat[i];
      if (phase == 0) begin
        phase = req ? 1 : 0;
      end else begin
        phase = (phase == 1) ? 2 : 0;   // Requests dropped while busy
      end
      e = '{cup: (phase == 2), cwr: (phase == 1), lev0: 1'b0};
      tick();
      check_cache("cache", e, cache);
    end
    drive_idle();
  endtask

  // Random interrupt levels with zero about a quarter of the time
  task automatic test_lev0;
    cmddec_ctrl_pkg::cache_strobe_t e;
    for (int i = 0; i < 40; i++) begin
      pil = ($urandom_range(3) == 0) ? 4'h0 : 4'($urandom);
      e   = '{cup: 1'b0, cwr: 1'b0, lev0: (pil == 4'h0)};
      tick();
      check_cache("cache", e, cache);
    end
    drive_idle();
  endtask

  initial begin
    void'($urandom(32'hc2d1_8464));
    rst_n = 1'b0;
    drive_idle();
    repeat (2) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    test_reset_pd();
    test_rf();
    test_cmd();
    test_brk();
    test_cache();
    test_lev0();
    tick();
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/cmd_idb_decode.sv */
////////////////////////////////////////////////////////////
// Command and IDB decode sheet
// Joins the register file, control store and cache
// decoders and forms the break line
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_idb_decode (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            pd1,       // Power down forces all strobes inactive
  input  cmddec_field_pkg::ucode_field_t ucode,     // Microinstruction slice
  input  wire                            idb2,
  input  wire                            lcs_n,     // Load control store
  input  wire                            wrtrf,     // Write register file
  input  cmddec_field_pkg::pil_t         pil,       // Interrupt level
  input  wire                            mreq_n,    // Memory request
  input  wire                            wca_n,     // Write cache
  input  wire                            cgabrk_n,  // Break from gate array
  output cmddec_ctrl_pkg::rf_strobe_t    rf,
  output cmddec_ctrl_pkg::cs_strobe_t    cs,
  output cmddec_ctrl_pkg::cache_strobe_t cache,
  output wire                            brk_n      // Active low break line
);

  // Break only when the gate array asks and no vector exception is flagged
  assign brk_n = cgabrk_n | cs.vex;

  // Register file strobes
  regfile_strobe_dec u_regfile_strobe_dec (
    .clk    (clk),
    .rst_n  (rst_n),
    .pd1    (pd1),
    .csidbs (ucode.csidbs),   // Only the IDB source field
    .wrtrf  (wrtrf),
    .lcs_n  (lcs_n),
    .rf     (rf)
  );

  // Control store commands and vector exception
  cstore_cmd_dec u_cstore_cmd_dec (
    .clk    (clk),
    .rst_n  (rst_n),
    .pd1    (pd1),
    .ucode  (ucode),
    .lcs_n  (lcs_n),
    .idb2   (idb2),
    .cs     (cs)
  );

  // Level zero and cache write sequence
  level_cache_dec u_level_cache_dec (
    .clk    (clk),
    .rst_n  (rst_n),
    .pd1    (pd1),
    .pil    (pil),
    .mreq_n (mreq_n),
    .wca_n  (wca_n),
    .cache  (cache)
  );

endmodule

`default_nettype wire

/* verilog/cmddec_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// Output strobe types for the command and IDB decode sheet
// Strobe groups per decoder and the cache-write state
////////////////////////////////////////////////////////////
`default_nettype none

package cmddec_ctrl_pkg;

  // Register file strobes, both active low
  typedef struct packed {
    logic erf_n;     // Enable register file write
    logic rrf_n;     // Read register file onto IDB
  } rf_strobe_t;

  // Control-store and exception strobes
  typedef struct packed {
    logic ldexm_n;   // Load examine register
    logic vex;       // Vector exception, active high
    logic opclcs;    // Opcode load from control store
    logic rwcs_n;    // Read/write control store
    logic rt_n;      // Return
  } cs_strobe_t;

  // Cache write sequence and level flag, all active high
  typedef struct packed {
    logic cup;       // Cache update, second access cycle
    logic cwr;       // Cache write, first access cycle
    logic lev0;      // Interrupt level is zero
  } cache_strobe_t;

  // Cache write sequencer
  typedef enum logic [1:0] {
    CACHE_IDLE   = 2'b00,
    CACHE_WRITE  = 2'b01,
    CACHE_UPDATE = 2'b10
  } cache_state_t;

  // Inactive values, used at reset and during pd1
  localparam rf_strobe_t    RF_OFF    = '{erf_n: 1'b1, rrf_n: 1'b1};
  localparam cs_strobe_t    CS_OFF    = '{ldexm_n: 1'b1, vex: 1'b0, opclcs: 1'b0,
                                          rwcs_n: 1'b1, rt_n: 1'b1};
  localparam cache_strobe_t CACHE_OFF = '{cup: 1'b0, cwr: 1'b0, lev0: 1'b0};

endpackage

`default_nettype wire

/* verilog/cmddec_defs.svh */
////////////////////////////////////////////////////////////
// Command and IDB decode field widths and decode codes
// Shared by the field package, the decoders and the testbench
////////////////////////////////////////////////////////////
`ifndef CMDDEC_DEFS_SVH
`define CMDDEC_DEFS_SVH

// Microinstruction field widths
`define CMDDEC_COMM_W 5   // Command field
`define CMDDEC_IDBS_W 5   // IDB source field
`define CMDDEC_MIS_W  2   // Misc field
`define CMDDEC_PIL_W  4   // Current interrupt level

// IDB source selecting the register file
`define IDBS_RF   5'h05

// Command codes seen by the control-store decoder
`define CMD_LDEXM 5'h0A   // Load examine register
`define CMD_VEX   5'h11   // Vector exception test
`define MIS_VEX   2'b01   // Misc qualifier for CMD_VEX
`define CMD_RWCS  5'h14   // Read/write control store
`define CMD_RET   5'h1E   // Return

`endif

/* verilog/cmddec_field_pkg.sv */
////////////////////////////////////////////////////////////
// Input field types for the command and IDB decode sheet
// Microinstruction slice plus the interrupt level
////////////////////////////////////////////////////////////
`default_nettype none

`include "cmddec_defs.svh"

package cmddec_field_pkg;

  // Command field of the current microinstruction
  typedef logic [`CMDDEC_COMM_W-1:0] cscomm_t;

  // Selects which unit drives the IDB
  typedef logic [`CMDDEC_IDBS_W-1:0] csidbs_t;

  // Misc qualifier bits
  typedef logic [`CMDDEC_MIS_W-1:0] csmis_t;

  // Current interrupt level from the interrupt logic
  typedef logic [`CMDDEC_PIL_W-1:0] pil_t;

  // Microinstruction slice used by the sheet
  // Command in the top bits, misc in the bottom
  typedef struct packed {
    cscomm_t cscomm;   // Bits 11:7
    csidbs_t csidbs;   // Bits 6:2
    csmis_t  csmis;    // Bits 1:0
  } ucode_field_t;

  // Idle microinstruction, handy for drive code
  localparam ucode_field_t UCODE_NOP = '{
    cscomm: '0,
    csidbs: '0,
    csmis:  '0
  };

endpackage

`default_nettype wire

/* verilog/cstore_cmd_dec.sv */
////////////////////////////////////////////////////////////
// Control-store command decode
// Command and misc fields to registered control-store
// strobes and the vector exception flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cmddec_defs.svh"

module cstore_cmd_dec (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          pd1,     // Power down
  input  cmddec_field_pkg::ucode_field_t ucode, // Current microinstruction slice
  input  wire                          lcs_n,   // Load control store
  input  wire                          idb2,    // IDB bit 2
  output cmddec_ctrl_pkg::cs_strobe_t  cs
);

  cmddec_field_pkg::cscomm_t   comm;   // Command field
  cmddec_field_pkg::csmis_t    mis;    // Misc field
  cmddec_ctrl_pkg::cs_strobe_t cs_d;   // Next strobe values

  // Per-command hits
  logic hit_ldexm;
  logic hit_vex;
  logic hit_rwcs;
  logic hit_ret;
  logic hit_opcl;   // Opcode fetch during control store load

  assign comm = ucode.cscomm;
  assign mis  = ucode.csmis;

  always_comb begin
    hit_ldexm = (comm == `CMD_LDEXM);
    hit_vex   = (comm == `CMD_VEX) && (mis == `MIS_VEX);   // Needs qualifier
    hit_rwcs  = (comm == `CMD_RWCS);
    hit_ret   = (comm == `CMD_RET);
    hit_opcl  = ~lcs_n & idb2;
  end

  // Pack into output polarity
  always_comb begin
    cs_d         = cmddec_ctrl_pkg::CS_OFF;
    cs_d.ldexm_n = ~hit_ldexm;
    cs_d.vex     = hit_vex;        // Active high, feeds break gate
    cs_d.opclcs  = hit_opcl;       // Active high
    cs_d.rwcs_n  = ~hit_rwcs;
    cs_d.rt_n    = ~hit_ret;
  end

  // Output register, no stall
  // A new command may enter every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cs <= cmddec_ctrl_pkg::CS_OFF;
    end else if (pd1) begin
      cs <= cmddec_ctrl_pkg::CS_OFF;   // Inactive while powered down
    end else begin
      cs <= cs_d;
    end
  end

  // Command strobes are mutually exclusive
  a_cmd_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({~cs.ldexm_n, ~cs.rwcs_n, ~cs.rt_n})
  ) else $error("more than one control-store command strobe low");

endmodule

`default_nettype wire

/* verilog/level_cache_dec.sv */
////////////////////////////////////////////////////////////
// Level-zero detect and cache write sequencer
// An accepted write gives one cycle of cwr, then one of cup
// Requests outside idle are dropped
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module level_cache_dec (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            pd1,     // Power down
  input  cmddec_field_pkg::pil_t         pil,     // Current interrupt level
  input  wire                            mreq_n,  // Memory request
  input  wire                            wca_n,   // Write cache strobe
  output cmddec_ctrl_pkg::cache_strobe_t cache
);

  cmddec_ctrl_pkg::cache_state_t state;
  cmddec_ctrl_pkg::cache_state_t state_nxt;
  logic                          wr_req;   // Write request this cycle
  logic                          lev0_q;   // Registered level-zero flag

  assign wr_req = ~mreq_n & ~wca_n;

  // Sequencer next state
  always_comb begin
    state_nxt = state;
    case (state)
      cmddec_ctrl_pkg::CACHE_IDLE: begin
        if (wr_req) begin
          state_nxt = cmddec_ctrl_pkg::CACHE_WRITE;   // Accept
        end
      end
      cmddec_ctrl_pkg::CACHE_WRITE: begin
        state_nxt = cmddec_ctrl_pkg::CACHE_UPDATE;    // Fixed length, no wait
      end
      cmddec_ctrl_pkg::CACHE_UPDATE: begin
        state_nxt = cmddec_ctrl_pkg::CACHE_IDLE;
      end
      default: begin
        state_nxt = cmddec_ctrl_pkg::CACHE_IDLE;      // Unused encoding
      end
    endcase
  end

  // State register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cmddec_ctrl_pkg::CACHE_IDLE;
    end else if (pd1) begin
      state <= cmddec_ctrl_pkg::CACHE_IDLE;   // Abort any access
    end else begin
      state <= state_nxt;
    end
  end

  // Level zero flag, one cycle from pil
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lev0_q <= 1'b0;
    end else if (pd1) begin
      lev0_q <= 1'b0;
    end else begin
      lev0_q <= (pil == '0);
    end
  end

  // Strobes straight from state flops
  assign cache.cwr  = (state == cmddec_ctrl_pkg::CACHE_WRITE);
  assign cache.cup  = (state == cmddec_ctrl_pkg::CACHE_UPDATE);
  assign cache.lev0 = lev0_q;

  // Write and update never overlap
  a_cwr_cup_excl : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cache.cwr && cache.cup)
  ) else $error("cwr and cup high together");

  // Update follows write unless powered down in between
  a_cup_after_cwr : assert property (
    @(posedge clk) disable iff (!rst_n)
    (cache.cwr && !pd1) |=> cache.cup
  ) else $error("cup missing after cwr");

endmodule

`default_nettype wire

/* verilog/regfile_strobe_dec.sv */
////////////////////////////////////////////////////////////
// Register file strobe decode
// Registers the IDB read and write enable strobes
// Forces both strobes inactive while pd1 is high
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cmddec_defs.svh"

module regfile_strobe_dec (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          pd1,      // Power down, outputs go inactive
  input  cmddec_field_pkg::csidbs_t    csidbs,   // IDB source field
  input  wire                          wrtrf,    // Write to register file
  input  wire                          lcs_n,    // Load control store, blocks both strobes
  output cmddec_ctrl_pkg::rf_strobe_t  rf
);

  cmddec_ctrl_pkg::rf_strobe_t rf_d;   // Next strobe values
  logic                        rd_sel; // IDB sourced from register file
  logic                        cs_busy;

  assign rd_sel  = (csidbs == `IDBS_RF);
  assign cs_busy = ~lcs_n;   // Control store load owns the cycle

  // Decode terms, active low out
  always_comb begin
    rf_d.rrf_n = ~(rd_sel & ~cs_busy);
    rf_d.erf_n = ~(wrtrf & ~cs_busy);
  end

  // Output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf <= cmddec_ctrl_pkg::RF_OFF;
    end else if (pd1) begin
      rf <= cmddec_ctrl_pkg::RF_OFF;   // Powered down
    end else begin
      rf <= rf_d;
    end
  end

  // Power down quiets the register file on the next cycle
  a_pd1_quiet : assert property (
    @(posedge clk) disable iff (!rst_n)
    pd1 |=> (rf.rrf_n && rf.erf_n)
  ) else $error("regfile strobe active after pd1");

endmodule

`default_nettype wire
